//--- tau_cfg_pkg.sv
// ==============================
// tau configuration package
// vector shape, data widths and storage sizes
// ==============================
package tau_cfg_pkg;

	// vector shape
	localparam int VSIZE = 4;
	localparam int DBW = 8;
	localparam int TDBW = 16;

	// sram bank
	localparam int SRAM_NWORD = 16;
	localparam int SRAM_ABW = $clog2(SRAM_NWORD);

	// register file and temp buffer
	localparam int NREG = 8;
	localparam int REG_ABW = $clog2(NREG);
	localparam int TBUF_SIZE = 2;

	typedef logic signed [TDBW-1:0] lane_t;
	typedef lane_t [VSIZE-1:0] vec_t;
	// sram and dram words are narrow
	typedef logic [VSIZE-1:0][DBW-1:0] dvec_t;

endpackage

//--- alu_isa_pkg.sv
// ==============================
// vector alu instruction set
// opcodes, operand sources, instruction word
// and the sram request
// ==============================
package alu_isa_pkg;
	import tau_cfg_pkg::*;

	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_SQD   = 3'd2,
		ALU_ABD   = 3'd3,
		ALU_MAC   = 3'd4,
		ALU_LOGIC = 3'd6
	} alu_op_e;

	typedef enum logic [2:0] {
		SRC_CONST = 3'd0,
		SRC_REG   = 3'd1,
		SRC_SRAM0 = 3'd2,
		SRC_SRAM1 = 3'd3,
		SRC_TBUF0 = 3'd4,
		SRC_TBUF1 = 3'd5
	} src_e;

	typedef struct packed {
		alu_op_e             opcode;
		src_e                src_a;
		src_e                src_b;
		src_e                src_c;
		lane_t               const_a;
		lane_t               const_b;
		lane_t               const_c;
		logic [4:0]          shamt;
		logic [REG_ABW-1:0]  rd_raddr;
		logic [SRAM_ABW-1:0] rd0_addr;
		logic [SRAM_ABW-1:0] rd1_addr;
		logic                to_reg;
		logic                to_temp;
		logic [REG_ABW-1:0]  reg_waddr;
		// 3 means no dram write
		logic [1:0]          dram_shift;
	} alu_inst_t;

	typedef struct packed {
		logic [SRAM_ABW-1:0] addr;
		logic                we;
		dvec_t               wdata;
	} sram_req_t;

endpackage

//--- rdyack_stage.sv
`timescale 1ns/1ps
// ==============================
// ready/acknowledge holding stage
// one register with a full flag, any payload type
// ==============================
module rdyack_stage #(
	parameter type payload_t = logic
) (
	input  logic     i_clk,
	input  logic     i_rst,
	input  logic     i_in_rdy,
	output logic     o_in_ack,
	input  payload_t i_in,
	output logic     o_out_rdy,
	input  logic     i_out_ack,
	output payload_t o_out
);

	logic     full;
	payload_t data;

	// take a new item when empty or when the held one leaves now
	assign o_in_ack = i_in_rdy && (!full || i_out_ack);
	assign o_out_rdy = full;
	assign o_out = data;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			full <= 1'b0;
		end else if (o_in_ack) begin
			full <= 1'b1;
		end else if (i_out_ack) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_in_ack) begin
			data <= i_in;
		end
	end

	a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_out_rdy && !i_out_ack |=> o_out_rdy && $stable(o_out));

endmodule

//--- sram_bank.sv
`timescale 1ns/1ps
// ==============================
// vector sram bank
// single port, registered read data
// ==============================
module sram_bank (
	input  logic                   i_clk,
	input  alu_isa_pkg::sram_req_t i_req,
	input  logic                   i_req_en,
	output tau_cfg_pkg::dvec_t     o_rdata
);
	import tau_cfg_pkg::*;

	dvec_t mem [SRAM_NWORD];

	always_ff @(posedge i_clk) begin
		if (i_req_en) begin
			if (i_req.we) begin
				mem[i_req.addr] <= i_req.wdata;
			end else begin
				o_rdata <= mem[i_req.addr];
			end
		end
	end

endmodule

//--- sram_arbiter.sv
`timescale 1ns/1ps
// ==============================
// sram bank arbiter
// round robin over the loader and two read streams,
// holds each stream's read data until acked
// ==============================
module sram_arbiter (
	input  logic                             i_clk,
	input  logic                             i_rst,
	input  logic                             i_ld_rdy,
	output logic                             o_ld_ack,
	input  logic [tau_cfg_pkg::SRAM_ABW-1:0] i_ld_addr,
	input  tau_cfg_pkg::dvec_t               i_ld_data,
	input  logic                             i_rd0_req,
	input  logic [tau_cfg_pkg::SRAM_ABW-1:0] i_rd0_addr,
	output logic                             o_rd0_rdy,
	output tau_cfg_pkg::dvec_t               o_rd0_data,
	input  logic                             i_rd0_ack,
	input  logic                             i_rd1_req,
	input  logic [tau_cfg_pkg::SRAM_ABW-1:0] i_rd1_addr,
	output logic                             o_rd1_rdy,
	output tau_cfg_pkg::dvec_t               o_rd1_data,
	input  logic                             i_rd1_ack,
	output alu_isa_pkg::sram_req_t           o_mem_req,
	output logic                             o_mem_en,
	input  tau_cfg_pkg::dvec_t               i_mem_rdata
);
	import tau_cfg_pkg::*;

	// requester 0 is the loader, 1 and 2 are the streams
	logic [2:0] req;
	logic [2:0] grant;
	logic [1:0] last;
	logic [1:0] gidx;
	logic [1:0] rd_req;
	logic [1:0] rd_ack;
	logic [1:0] inflight;
	logic [1:0] pend;
	dvec_t      hold [2];

	assign rd_req = {i_rd1_req, i_rd0_req};
	assign rd_ack = {i_rd1_ack, i_rd0_ack};
	// a stream with data in flight or still waiting sits out
	assign req = {rd_req & ~inflight & ~pend, i_ld_rdy};

	// ============================
	// grant
	// ============================
	always_comb begin
		int idx;
		grant = '0;
		// search starts just after the last winner
		for (int k = 1; k <= 3; k++) begin
			idx = (int'(last) + k) % 3;
			if (grant == '0 && req[idx]) begin
				grant[idx] = 1'b1;
			end
		end
	end

	assign gidx = grant[2] ? 2'd2 : (grant[1] ? 2'd1 : 2'd0);
	assign o_ld_ack = grant[0];
	assign o_mem_en = |grant;

	always_comb begin
		o_mem_req.we = grant[0];
		o_mem_req.addr = grant[0] ? i_ld_addr : (grant[1] ? i_rd0_addr : i_rd1_addr);
		o_mem_req.wdata = i_ld_data;
	end

	// ============================
	// read return
	// ============================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			last <= 2'd2;
			inflight <= '0;
			pend <= '0;
		end else begin
			if (|grant) begin
				last <= gidx;
			end
			inflight <= grant[2:1];
			pend <= inflight | (pend & ~rd_ack);
		end
	end

	// bank data is valid the cycle after the grant
	always_ff @(posedge i_clk) begin
		for (int s = 0; s < 2; s++) begin
			if (inflight[s]) begin
				hold[s] <= i_mem_rdata;
			end
		end
	end

	assign o_rd0_rdy = pend[0];
	assign o_rd1_rdy = pend[1];
	assign o_rd0_data = hold[0];
	assign o_rd1_data = hold[1];

	a_grant_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
		|req |-> $onehot(grant));

	for (genvar s = 0; s < 2; s++) begin : g_hold_chk
		a_data_hold: assert property (@(posedge i_clk) disable iff (i_rst)
			pend[s] && !rd_ack[s] |=> pend[s] && $stable(hold[s]));
	end

endmodule

//--- operand_store.sv
`timescale 1ns/1ps
// ==============================
// operand store
// vector register file and the temp buffer
// ==============================
module operand_store (
	input  logic                            i_clk,
	input  logic                            i_rst,
	input  logic [tau_cfg_pkg::REG_ABW-1:0] i_raddr,
	output tau_cfg_pkg::vec_t               o_rdata,
	input  logic                            i_reg_we,
	input  logic [tau_cfg_pkg::REG_ABW-1:0] i_reg_waddr,
	input  tau_cfg_pkg::vec_t               i_wdata,
	input  logic                            i_tbuf_we,
	output tau_cfg_pkg::vec_t               o_tbuf0,
	output tau_cfg_pkg::vec_t               o_tbuf1
);
	import tau_cfg_pkg::*;

	vec_t regs [NREG];
	vec_t tbuf [TBUF_SIZE];

	// asynchronous read port
	assign o_rdata = regs[i_raddr];
	assign o_tbuf0 = tbuf[0];
	assign o_tbuf1 = tbuf[1];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int r = 0; r < NREG; r++) begin
				regs[r] <= '0;
			end
			for (int t = 0; t < TBUF_SIZE; t++) begin
				tbuf[t] <= '0;
			end
		end else begin
			if (i_reg_we) begin
				regs[i_reg_waddr] <= i_wdata;
			end
			// a push moves the older result down one slot
			if (i_tbuf_we) begin
				tbuf[0] <= i_wdata;
				for (int t = 1; t < TBUF_SIZE; t++) begin
					tbuf[t] <= tbuf[t-1];
				end
			end
		end
	end

endmodule

//--- vector_alu.sv
`timescale 1ns/1ps
// ==============================
// vector alu
// operand select, six operations, commit and write-back
// ==============================
module vector_alu (
	input  logic                             i_clk,
	input  logic                             i_rst,
	input  logic                             i_op_rdy,
	output logic                             o_op_ack,
	input  alu_isa_pkg::alu_inst_t           i_inst,
	input  logic                             i_rd0_rdy,
	input  tau_cfg_pkg::dvec_t               i_rd0_data,
	output logic                             o_rd0_req,
	output logic [tau_cfg_pkg::SRAM_ABW-1:0] o_rd0_addr,
	output logic                             o_rd0_ack,
	input  logic                             i_rd1_rdy,
	input  tau_cfg_pkg::dvec_t               i_rd1_data,
	output logic                             o_rd1_req,
	output logic [tau_cfg_pkg::SRAM_ABW-1:0] o_rd1_addr,
	output logic                             o_rd1_ack,
	input  tau_cfg_pkg::vec_t                i_rdata,
	input  tau_cfg_pkg::vec_t                i_tbuf0,
	input  tau_cfg_pkg::vec_t                i_tbuf1,
	output logic [tau_cfg_pkg::REG_ABW-1:0]  o_reg_raddr,
	output logic                             o_reg_we,
	output logic [tau_cfg_pkg::REG_ABW-1:0]  o_reg_waddr,
	output tau_cfg_pkg::vec_t                o_wdata,
	output logic                             o_tbuf_we,
	output logic                             o_dramwd_rdy,
	input  logic                             i_dramwd_ack,
	output tau_cfg_pkg::dvec_t               o_dramwd,
	output logic                             o_commit
);
	import tau_cfg_pkg::*;
	import alu_isa_pkg::*;

	logic to_dram;
	logic need_rd0;
	logic need_rd1;
	logic data_ready;
	vec_t sel_a;
	vec_t sel_b;
	vec_t sel_c;
	vec_t result;

	// ============================
	// operand select
	// ============================
	function automatic vec_t sext_dvec(dvec_t d);
		vec_t v;
		for (int i = 0; i < VSIZE; i++) begin
			v[i] = $signed(d[i]);
		end
		return v;
	endfunction

	function automatic vec_t select_operand(src_e src, lane_t cval, vec_t rdata,
		dvec_t rd0, dvec_t rd1, vec_t tb0, vec_t tb1);
		vec_t v;
		case (src)
			SRC_CONST: v = {VSIZE{cval}};
			SRC_REG:   v = rdata;
			SRC_SRAM0: v = sext_dvec(rd0);
			SRC_SRAM1: v = sext_dvec(rd1);
			SRC_TBUF0: v = tb0;
			SRC_TBUF1: v = tb1;
			default:   v = '0;
		endcase
		return v;
	endfunction

	// ============================
	// lane operations
	// ============================
	function automatic lane_t alu_lane(alu_op_e op, logic [4:0] sh, lane_t a, lane_t b,
		lane_t c);
		lane_t d;
		logic signed [DBW-1:0] d8;
		lane_t p;
		d = b - c;
		d8 = b[DBW-1:0] - c[DBW-1:0];
		// narrow products keep the low TDBW bits
		p = (op == ALU_SQD) ? d8 * d8 : $signed(b[DBW-1:0]) * $signed(c[DBW-1:0]);
		case (op)
			ALU_ADD: return a + ((b + c) >>> sh);
			ALU_SUB: return a + (d >>> sh);
			ALU_SQD, ALU_MAC: return a + (p >>> sh);
			ALU_ABD: return a + (((d > 0) ? d : -d) >>> sh);
			ALU_LOGIC: begin
				case (sh)
					5'd0: return (a == 0) ? b : c;
					5'd2: return (b > c) ? b : c;
					5'd3: return (b < c) ? b : c;
					default: return '0;
				endcase
			end
			default: return '0;
		endcase
	endfunction

	always_comb begin
		sel_a = select_operand(i_inst.src_a, i_inst.const_a, i_rdata, i_rd0_data,
			i_rd1_data, i_tbuf0, i_tbuf1);
		sel_b = select_operand(i_inst.src_b, i_inst.const_b, i_rdata, i_rd0_data,
			i_rd1_data, i_tbuf0, i_tbuf1);
		sel_c = select_operand(i_inst.src_c, i_inst.const_c, i_rdata, i_rd0_data,
			i_rd1_data, i_tbuf0, i_tbuf1);
	end

	always_comb begin
		lane_t shifted;
		for (int i = 0; i < VSIZE; i++) begin
			result[i] = alu_lane(i_inst.opcode, i_inst.shamt, sel_a[i], sel_b[i], sel_c[i]);
			shifted = result[i] >>> {i_inst.dram_shift, 1'b0};
			o_dramwd[i] = shifted[DBW-1:0];
		end
	end

	// ============================
	// commit
	// ============================
	always_comb begin
		to_dram = i_inst.dram_shift != 2'b11;
		need_rd0 = i_inst.src_a == SRC_SRAM0 || i_inst.src_b == SRC_SRAM0 ||
			i_inst.src_c == SRC_SRAM0;
		need_rd1 = i_inst.src_a == SRC_SRAM1 || i_inst.src_b == SRC_SRAM1 ||
			i_inst.src_c == SRC_SRAM1;
		data_ready = i_op_rdy && (!need_rd0 || i_rd0_rdy) && (!need_rd1 || i_rd1_rdy);
		o_dramwd_rdy = data_ready && to_dram;
		o_op_ack = (o_dramwd_rdy && i_dramwd_ack) || (data_ready && !to_dram);
		o_commit = o_op_ack;
		o_reg_we = o_op_ack && i_inst.to_reg;
		o_tbuf_we = o_op_ack && i_inst.to_temp;
		o_rd0_req = i_op_rdy && need_rd0;
		o_rd1_req = i_op_rdy && need_rd1;
		o_rd0_ack = o_op_ack && need_rd0;
		o_rd1_ack = o_op_ack && need_rd1;
	end

	assign o_rd0_addr = i_inst.rd0_addr;
	assign o_rd1_addr = i_inst.rd1_addr;
	assign o_reg_raddr = i_inst.rd_raddr;
	assign o_reg_waddr = i_inst.reg_waddr;
	assign o_wdata = result;

	// the held instruction keeps asking until its stream data returns
	a_rd0_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_rd0_req && !i_rd0_rdy |=> o_rd0_req);
	a_rd1_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_rd1_req && !i_rd1_rdy |=> o_rd1_req);

endmodule

//--- alu_top.sv
`timescale 1ns/1ps
// ==============================
// vector alu stage top
// instruction stage, alu, sram path, store, dram stage
// ==============================
module alu_top (
	input  logic                             i_clk,
	input  logic                             i_rst,
	input  logic                             i_inst_rdy,
	output logic                             o_inst_ack,
	input  alu_isa_pkg::alu_inst_t           i_inst,
	input  logic                             i_ld_rdy,
	output logic                             o_ld_ack,
	input  logic [tau_cfg_pkg::SRAM_ABW-1:0] i_ld_addr,
	input  tau_cfg_pkg::dvec_t               i_ld_data,
	output logic                             o_dramwd_rdy,
	input  logic                             i_dramwd_ack,
	output tau_cfg_pkg::dvec_t               o_dramwd,
	output logic                             o_commit
);
	import tau_cfg_pkg::*;
	import alu_isa_pkg::*;

	// instruction and sram path
	logic                op_rdy;
	logic                op_ack;
	alu_inst_t           inst;
	logic                rd0_req;
	logic                rd1_req;
	logic [SRAM_ABW-1:0] rd0_addr;
	logic [SRAM_ABW-1:0] rd1_addr;
	logic                rd0_rdy;
	logic                rd1_rdy;
	logic                rd0_ack;
	logic                rd1_ack;
	dvec_t               rd0_data;
	dvec_t               rd1_data;
	sram_req_t           mem_req;
	logic                mem_en;
	dvec_t               mem_rdata;

	// store and dram path
	logic [REG_ABW-1:0]  reg_raddr;
	logic [REG_ABW-1:0]  reg_waddr;
	logic                reg_we;
	logic                tbuf_we;
	vec_t                rdata;
	vec_t                wdata;
	vec_t                tbuf0;
	vec_t                tbuf1;
	logic                alu_dram_rdy;
	logic                alu_dram_ack;
	dvec_t               alu_dram;

	rdyack_stage #(.payload_t(alu_inst_t)) inst_stage (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_in_rdy(i_inst_rdy), .o_in_ack(o_inst_ack), .i_in(i_inst),
		.o_out_rdy(op_rdy), .i_out_ack(op_ack), .o_out(inst)
	);

	sram_arbiter u_arbiter (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_ld_rdy(i_ld_rdy), .o_ld_ack(o_ld_ack), .i_ld_addr(i_ld_addr), .i_ld_data(i_ld_data),
		.i_rd0_req(rd0_req), .i_rd0_addr(rd0_addr), .o_rd0_rdy(rd0_rdy),
		.o_rd0_data(rd0_data), .i_rd0_ack(rd0_ack),
		.i_rd1_req(rd1_req), .i_rd1_addr(rd1_addr), .o_rd1_rdy(rd1_rdy),
		.o_rd1_data(rd1_data), .i_rd1_ack(rd1_ack),
		.o_mem_req(mem_req), .o_mem_en(mem_en), .i_mem_rdata(mem_rdata)
	);

	sram_bank u_bank (
		.i_clk(i_clk), .i_req(mem_req), .i_req_en(mem_en), .o_rdata(mem_rdata)
	);

	operand_store u_store (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_raddr(reg_raddr), .o_rdata(rdata),
		.i_reg_we(reg_we), .i_reg_waddr(reg_waddr), .i_wdata(wdata),
		.i_tbuf_we(tbuf_we), .o_tbuf0(tbuf0), .o_tbuf1(tbuf1)
	);

	vector_alu u_alu (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_op_rdy(op_rdy), .o_op_ack(op_ack), .i_inst(inst),
		.i_rd0_rdy(rd0_rdy), .i_rd0_data(rd0_data), .o_rd0_req(rd0_req),
		.o_rd0_addr(rd0_addr), .o_rd0_ack(rd0_ack),
		.i_rd1_rdy(rd1_rdy), .i_rd1_data(rd1_data), .o_rd1_req(rd1_req),
		.o_rd1_addr(rd1_addr), .o_rd1_ack(rd1_ack),
		.i_rdata(rdata), .i_tbuf0(tbuf0), .i_tbuf1(tbuf1), .o_reg_raddr(reg_raddr),
		.o_reg_we(reg_we), .o_reg_waddr(reg_waddr), .o_wdata(wdata), .o_tbuf_we(tbuf_we),
		.o_dramwd_rdy(alu_dram_rdy), .i_dramwd_ack(alu_dram_ack), .o_dramwd(alu_dram),
		.o_commit(o_commit)
	);

	rdyack_stage #(.payload_t(dvec_t)) dram_stage (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_in_rdy(alu_dram_rdy), .o_in_ack(alu_dram_ack), .i_in(alu_dram),
		.o_out_rdy(o_dramwd_rdy), .i_out_ack(i_dramwd_ack), .o_out(o_dramwd)
	);

endmodule

//--- tb_alu_top.sv
`timescale 1ns/1ps
// ==============================
// vector alu stage testbench
// loads the sram, runs every opcode and source,
// checks dram words against a reference model
// ==============================
module tb_alu_top;
	import tau_cfg_pkg::*;
	import alu_isa_pkg::*;

	localparam logic [31:0] SEED = 32'h093f4896;
	localparam int N_P2 = 24;
	localparam int N_P3 = 16;
	localparam int N_P4 = 5;
	localparam int N_P5 = 20;
	localparam int N_INST = N_P2 + N_P3 + N_P4 + N_P5;
	localparam int TIMEOUT = 40 * N_INST + 200;

	logic                i_clk;
	logic                i_rst;
	logic                i_inst_rdy;
	logic                o_inst_ack;
	alu_inst_t           i_inst;
	logic                i_ld_rdy;
	logic                o_ld_ack;
	logic [SRAM_ABW-1:0] i_ld_addr;
	dvec_t               i_ld_data;
	logic                o_dramwd_rdy;
	logic                i_dramwd_ack;
	dvec_t               o_dramwd;
	logic                o_commit;

	// reference model state
	dvec_t sram_m [SRAM_NWORD];
	vec_t  reg_m [NREG];
	vec_t  tbuf_m [TBUF_SIZE];
	// expected dram words in commit order
	dvec_t exp_mem [N_INST];
	dvec_t exp_head;
	int    exp_wr;
	int    exp_rd;

	logic [31:0] rng = SEED;
	logic        started;
	logic        ack_gaps;
	logic        check_end;
	int          sent_cnt;
	int          acc_cnt;
	int          commit_cnt;
	int          cycle_cnt;
	int          data_errs;
	int          proto_errs;

	alu_op_e    ops [6] = '{ALU_ADD, ALU_SUB, ALU_SQD, ALU_ABD, ALU_MAC, ALU_LOGIC};
	logic [4:0] logic_modes [4] = '{5'd0, 5'd2, 5'd3, 5'd9};

	alu_top UUT (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_inst_rdy(i_inst_rdy), .o_inst_ack(o_inst_ack), .i_inst(i_inst),
		.i_ld_rdy(i_ld_rdy), .o_ld_ack(o_ld_ack), .i_ld_addr(i_ld_addr), .i_ld_data(i_ld_data),
		.o_dramwd_rdy(o_dramwd_rdy), .i_dramwd_ack(i_dramwd_ack), .o_dramwd(o_dramwd),
		.o_commit(o_commit)
	);

	assign exp_head = exp_mem[exp_rd];

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// ============================
	// random numbers and stimulus
	// ============================
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic alu_op_e rand_op();
		logic [2:0] op;
		op = 3'(next_rand() % 6);
		// opcode 5 is not used
		if (op == 3'd5) begin
			op = 3'd6;
		end
		return alu_op_e'(op);
	endfunction

	// three choices give a constant or an sram stream, six give any source
	function automatic src_e rand_src(int n);
		logic [2:0] s;
		s = 3'(next_rand() % n);
		if (n == 3 && s != 3'd0) begin
			s = s + 3'd1;
		end
		return src_e'(s);
	endfunction

	function automatic alu_inst_t rand_inst(alu_op_e op, int n);
		alu_inst_t inst;
		logic [31:0] r;
		inst = '0;
		inst.opcode = op;
		inst.src_a = rand_src(n);
		inst.src_b = rand_src(n);
		inst.src_c = rand_src(n);
		inst.const_a = lane_t'(next_rand());
		inst.const_b = lane_t'(next_rand());
		inst.const_c = lane_t'(next_rand());
		r = next_rand();
		// mostly small shifts so results keep their low bits
		inst.shamt = r[5] ? r[4:0] : {2'b00, r[2:0]};
		inst.rd_raddr = REG_ABW'(r >> 6);
		inst.rd0_addr = SRAM_ABW'(r >> 9);
		inst.rd1_addr = SRAM_ABW'(r >> 13);
		inst.reg_waddr = REG_ABW'(r >> 17);
		inst.dram_shift = 2'(r[21:20] % 3);
		return inst;
	endfunction

	// ============================
	// reference model
	// ============================
	function automatic vec_t widen(dvec_t d);
		vec_t v;
		logic signed [DBW-1:0] w;
		for (int i = 0; i < VSIZE; i++) begin
			w = d[i];
			v[i] = w;
		end
		return v;
	endfunction

	function automatic vec_t pick_operand(src_e src, lane_t cval, alu_inst_t inst);
		vec_t v;
		v = '0;
		case (src)
			SRC_CONST: begin
				for (int i = 0; i < VSIZE; i++) begin
					v[i] = cval;
				end
			end
			SRC_REG:   v = reg_m[inst.rd_raddr];
			SRC_SRAM0: v = widen(sram_m[inst.rd0_addr]);
			SRC_SRAM1: v = widen(sram_m[inst.rd1_addr]);
			SRC_TBUF0: v = tbuf_m[0];
			SRC_TBUF1: v = tbuf_m[1];
			default:   v = '0;
		endcase
		return v;
	endfunction

	function automatic lane_t ref_lane(alu_op_e op, logic [4:0] sh, lane_t a, lane_t b,
		lane_t c);
		logic signed [DBW-1:0] b_lo;
		logic signed [DBW-1:0] c_lo;
		logic signed [DBW-1:0] d_lo;
		lane_t bw;
		lane_t cw;
		lane_t dw;
		lane_t t;
		lane_t res;
		b_lo = b[DBW-1:0];
		c_lo = c[DBW-1:0];
		d_lo = b_lo - c_lo;
		bw = b_lo;
		cw = c_lo;
		dw = d_lo;
		t = '0;
		case (op)
			ALU_ADD: t = b + c;
			ALU_SUB: t = b - c;
			ALU_SQD: t = dw * dw;
			ALU_ABD: begin
				t = b - c;
				if (t < 0) begin
					t = -t;
				end
			end
			ALU_MAC: t = bw * cw;
			default: t = '0;
		endcase
		res = a + (t >>> sh);
		if (op == ALU_LOGIC) begin
			case (sh)
				5'd0:    res = (a == 0) ? b : c;
				5'd2:    res = (b > c) ? b : c;
				5'd3:    res = (b < c) ? b : c;
				default: res = '0;
			endcase
		end
		return res;
	endfunction

	function automatic vec_t model_result(alu_inst_t inst);
		vec_t a;
		vec_t b;
		vec_t c;
		vec_t r;
		a = pick_operand(inst.src_a, inst.const_a, inst);
		b = pick_operand(inst.src_b, inst.const_b, inst);
		c = pick_operand(inst.src_c, inst.const_c, inst);
		for (int i = 0; i < VSIZE; i++) begin
			r[i] = ref_lane(inst.opcode, inst.shamt, a[i], b[i], c[i]);
		end
		return r;
	endfunction

	function automatic dvec_t dram_word(vec_t r, logic [1:0] ds);
		dvec_t w;
		lane_t s;
		for (int i = 0; i < VSIZE; i++) begin
			s = r[i];
			s = s >>> (2 * ds);
			w[i] = s[DBW-1:0];
		end
		return w;
	endfunction

	// ============================
	// handshakes
	// ============================
	task automatic send_inst(input alu_inst_t inst);
		vec_t r;
		logic acked;
		r = model_result(inst);
		if (inst.to_reg) begin
			reg_m[inst.reg_waddr] = r;
		end
		if (inst.to_temp) begin
			tbuf_m[1] = tbuf_m[0];
			tbuf_m[0] = r;
		end
		if (inst.dram_shift != 2'd3) begin
			exp_mem[exp_wr] = dram_word(r, inst.dram_shift);
			exp_wr++;
		end
		sent_cnt++;
		i_inst = inst;
		i_inst_rdy = 1'b1;
		acked = 1'b0;
		while (!acked) begin
			@(negedge i_clk);
			acked = o_inst_ack;
			@(posedge i_clk);
			#1;
		end
		i_inst_rdy = 1'b0;
	endtask

	task automatic load_word(input logic [SRAM_ABW-1:0] addr, input dvec_t data);
		logic acked;
		i_ld_addr = addr;
		i_ld_data = data;
		i_ld_rdy = 1'b1;
		acked = 1'b0;
		while (!acked) begin
			@(negedge i_clk);
			acked = o_ld_ack;
			@(posedge i_clk);
			#1;
		end
		i_ld_rdy = 1'b0;
	endtask

	task automatic report_errors();
		$display("errors: data %0d, protocol %0d", data_errs, proto_errs);
	endtask

	// dram sink acks with random gaps in the last phase
	initial begin
		logic [31:0] r;
		logic        ack;
		r = SEED;
		forever begin
			@(posedge i_clk);
			// the gap pattern runs from its own generator state
			r = xorshift(r);
			ack = started && (!ack_gaps || r[0]);
			#1;
			i_dramwd_ack = ack;
		end
	end

	always @(posedge i_clk) begin
		if (i_rst) begin
			exp_rd <= 0;
			commit_cnt <= 0;
			acc_cnt <= 0;
		end else begin
			if (o_dramwd_rdy && i_dramwd_ack) begin
				exp_rd <= exp_rd + 1;
			end
			if (o_commit) begin
				commit_cnt <= commit_cnt + 1;
			end
			if (o_inst_ack) begin
				acc_cnt <= acc_cnt + 1;
			end
		end
	end

	// ============================
	// checks
	// ============================
	a_idle: assert property (@(posedge i_clk) disable iff (i_rst)
		!started |-> !o_dramwd_rdy && !o_commit && !o_inst_ack)
		else begin
			proto_errs++;
			$display("DUT output went active before stimulus started");
		end

	a_dram_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		o_dramwd_rdy && !i_dramwd_ack |=> o_dramwd_rdy && $stable(o_dramwd))
		else begin
			proto_errs++;
			$display("o_dramwd_rdy dropped or o_dramwd changed before its ack");
		end

	a_dram_known: assert property (@(posedge i_clk) disable iff (i_rst)
		o_dramwd_rdy && i_dramwd_ack |-> exp_rd < exp_wr)
		else begin
			data_errs++;
			$display("DRAM write arrived with no expected result left");
		end

	a_dram_data: assert property (@(posedge i_clk) disable iff (i_rst)
		o_dramwd_rdy && i_dramwd_ack |-> o_dramwd == exp_head)
		else begin
			data_errs++;
			$display("[ERROR] o_dramwd got %h expected %h", $sampled(o_dramwd),
				$sampled(exp_head));
		end

	a_commit_bound: assert property (@(posedge i_clk) disable iff (i_rst)
		o_commit |-> commit_cnt < acc_cnt)
		else begin
			proto_errs++;
			$display("[ERROR] o_commit count %h exceeds accepted %h", $sampled(commit_cnt),
				$sampled(acc_cnt));
		end

	a_end: assert property (@(posedge i_clk)
		check_end |-> commit_cnt == sent_cnt && acc_cnt == sent_cnt && exp_rd == exp_wr)
		else begin
			proto_errs++;
			$display("[ERROR] commit_cnt %h acc_cnt %h sent %h, dram read %h written %h",
				$sampled(commit_cnt), $sampled(acc_cnt), $sampled(sent_cnt),
				$sampled(exp_rd), $sampled(exp_wr));
		end

	// ============================
	// timeout
	// ============================
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT) begin
			@(posedge i_clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT);
		report_errors();
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ============================
	// main sequence
	// ============================
	initial begin
		alu_inst_t inst;
		i_rst = 1'b1;
		i_inst_rdy = 1'b0;
		i_inst = '0;
		i_ld_rdy = 1'b0;
		i_ld_addr = '0;
		i_ld_data = '0;
		i_dramwd_ack = 1'b0;
		started = 1'b0;
		ack_gaps = 1'b0;
		check_end = 1'b0;
		sent_cnt = 0;
		exp_wr = 0;
		data_errs = 0;
		proto_errs = 0;
		for (int r = 0; r < NREG; r++) begin
			reg_m[r] = '0;
		end
		for (int t = 0; t < TBUF_SIZE; t++) begin
			tbuf_m[t] = '0;
		end
		repeat (4) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		repeat (3) @(posedge i_clk);
		#1;
		started = 1'b1;

		// fill the bank with random vectors
		for (int a = 0; a < SRAM_NWORD; a++) begin
			sram_m[a] = next_rand();
			load_word(SRAM_ABW'(a), sram_m[a]);
		end

		// every opcode on constant and sram operands, all logic modes
		foreach (ops[o]) begin
			for (int k = 0; k < 4; k++) begin
				inst = rand_inst(ops[o], 3);
				inst.dram_shift = 2'(k % 3);
				if (ops[o] == ALU_LOGIC) begin
					inst.shamt = logic_modes[k];
				end
				send_inst(inst);
			end
		end

		// both streams together while the loader rewrites the same contents
		fork
			begin
				for (int p = 0; p < 2; p++) begin
					for (int a = 0; a < SRAM_NWORD; a++) begin
						load_word(SRAM_ABW'(a), sram_m[a]);
						@(posedge i_clk);
						#1;
					end
				end
			end
			begin
				for (int n = 0; n < N_P3; n++) begin
					inst = rand_inst(rand_op(), 3);
					inst.src_b = SRC_SRAM0;
					inst.src_c = SRC_SRAM1;
					send_inst(inst);
				end
			end
		join

		// write a register and the temp buffer without a dram word
		inst = rand_inst(ALU_ADD, 3);
		inst.to_reg = 1'b1;
		inst.to_temp = 1'b1;
		inst.reg_waddr = REG_ABW'(3);
		inst.dram_shift = 2'd3;
		send_inst(inst);
		inst = rand_inst(ALU_MAC, 3);
		inst.to_reg = 1'b1;
		inst.to_temp = 1'b1;
		inst.reg_waddr = REG_ABW'(5);
		inst.dram_shift = 2'd3;
		send_inst(inst);

		// read them back as operands
		inst = rand_inst(ALU_ADD, 3);
		inst.src_a = SRC_REG;
		inst.rd_raddr = REG_ABW'(3);
		inst.src_b = SRC_TBUF0;
		inst.src_c = SRC_TBUF1;
		send_inst(inst);
		inst = rand_inst(ALU_SUB, 3);
		inst.src_a = SRC_REG;
		inst.rd_raddr = REG_ABW'(5);
		inst.src_b = SRC_TBUF1;
		inst.src_c = SRC_TBUF0;
		send_inst(inst);
		inst = rand_inst(ALU_LOGIC, 3);
		inst.src_a = SRC_TBUF0;
		inst.src_b = SRC_REG;
		inst.rd_raddr = REG_ABW'(3);
		inst.src_c = SRC_TBUF1;
		inst.shamt = 5'd2;
		send_inst(inst);

		// fully random instructions under dram back-pressure
		ack_gaps = 1'b1;
		for (int n = 0; n < N_P5; n++) begin
			logic [31:0] r;
			inst = rand_inst(rand_op(), 6);
			r = next_rand();
			inst.to_reg = r[0];
			inst.to_temp = r[1];
			inst.dram_shift = r[3:2];
			send_inst(inst);
		end
		ack_gaps = 1'b0;

		// drain, then compare the counts
		while (exp_rd != exp_wr || commit_cnt < sent_cnt) begin
			@(posedge i_clk);
			#1;
		end
		repeat (2) begin
			@(posedge i_clk);
			#1;
		end
		check_end = 1'b1;
		@(posedge i_clk);
		#1;
		check_end = 1'b0;
		@(posedge i_clk);
		#1;
		report_errors();
		if (data_errs == 0 && proto_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- vec_alu.f
tau_cfg_pkg.sv
alu_isa_pkg.sv
rdyack_stage.sv
sram_bank.sv
sram_arbiter.sv
operand_store.sv
vector_alu.sv
alu_top.sv
tb_alu_top.sv
